// File: run_sim.sh
#!/bin/sh
# Build and run the rate controller testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_pipe_rate -f verilog.f \
    --Mdir obj_dir -o sim_tb > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
    echo "Simulation log has no result line"
    exit 1
fi
exit 0

// File: sim/gt_lane_model.sv
module gt_lane_model
    import pipe_rate_pkg::*;
(
    input  logic      RATE_CLK,
    input  logic      drp_en,
    input  logic      drp_we,
    input  drp_addr_t drp_addr,
    input  drp_data_t drp_di,
    input  logic      txsync_start,
    output logic      drp_rdy,
    output logic      rxpmaresetdone,
    output logic      txratedone,
    output logic      rxratedone,
    output logic      phystatus,
    output logic      txsync_done,
    output logic      events_done,
    output logic      sync_done
);

    event      rate_go;
    drp_addr_t last_addr;
    drp_data_t last_wr;

    // Each DRP write is answered after 1 to 20 cycles.
    initial
    begin
        drp_rdy = 1'b0;
        forever
        begin
            @(posedge RATE_CLK);
            if (drp_en && drp_we)
            begin
                last_addr = drp_addr;
                last_wr   = drp_di;
                repeat ($urandom_range(20, 1)) @(negedge RATE_CLK);
                drp_rdy = 1'b1;
                @(negedge RATE_CLK);
                drp_rdy = 1'b0;
                if ((last_addr == DRP_ADDR_WIDTH_CFG) && (last_wr == DRP_VAL_X16))
                    ->rate_go; // The lane applies its new rate right after the width drop.
            end
        end
    end

    initial
    begin
        rxpmaresetdone = 1'b1;
        txratedone     = 1'b0;
        rxratedone     = 1'b0;
        phystatus      = 1'b0;
        events_done    = 1'b0;
        forever
        begin
            @(rate_go);
            events_done = 1'b0;
            fork
                begin
                    repeat (4 + $urandom_range(10, 0)) @(negedge RATE_CLK);
                    rxpmaresetdone = 1'b0;
                    repeat (4 + $urandom_range(4, 0)) @(negedge RATE_CLK);
                    rxpmaresetdone = 1'b1;
                end
                begin
                    repeat (4 + $urandom_range(30, 0)) @(negedge RATE_CLK);
                    txratedone = 1'b1;
                    repeat (4) @(negedge RATE_CLK);
                    txratedone = 1'b0;
                end
                begin
                    repeat (4 + $urandom_range(30, 0)) @(negedge RATE_CLK);
                    rxratedone = 1'b1;
                    repeat (4) @(negedge RATE_CLK);
                    rxratedone = 1'b0;
                end
                begin
                    repeat (4 + $urandom_range(30, 0)) @(negedge RATE_CLK);
                    phystatus = 1'b1;
                    repeat (4) @(negedge RATE_CLK);
                    phystatus = 1'b0;
                end
            join
            events_done = 1'b1;
        end
    end

    // TX phase sync: txsync_done drops, then comes back.
    initial
    begin
        txsync_done = 1'b1;
        sync_done   = 1'b0;
        forever
        begin
            @(rate_go);
            sync_done = 1'b0;
            do
                @(posedge RATE_CLK);
            while (!txsync_start);
            repeat ($urandom_range(5, 1)) @(negedge RATE_CLK);
            txsync_done = 1'b0;
            repeat (4 + $urandom_range(4, 0)) @(negedge RATE_CLK);
            txsync_done = 1'b1;
            sync_done   = 1'b1;
        end
    end

endmodule

// File: sim/tb_checker.sv
module tb_checker
    import pipe_rate_pkg::*;
#(
    parameter int LANES = 4
) (
    input  logic                  RATE_CLK,
    input  logic                  RATE_RST_N,
    input  pcie_rate_t            req,
    input  logic      [1:0]       test_kind,
    input  logic                  test_end,
    input  int                    test_num,
    input  logic      [LANES-1:0] pclk_sel,
    input  gt_rate_t  [LANES-1:0] rate_out,
    input  logic      [LANES-1:0] txsync_start,
    input  logic      [LANES-1:0] drp_en,
    input  logic      [LANES-1:0] drp_we,
    input  drp_addr_t [LANES-1:0] drp_addr,
    input  drp_data_t [LANES-1:0] drp_di,
    input  logic      [LANES-1:0] drp_rdy,
    input  logic                  rate_done,
    input  logic                  rate_idle,
    input  logic      [LANES-1:0] events_done,
    input  logic      [LANES-1:0] sync_done,
    output int                    errors,
    output int                    tests_run,
    output int                    tests_failed
);

    int         wr_idx [LANES];
    logic       outstanding [LANES];
    logic [LANES-1:0] txsync_prev;
    int         done_cnt;
    int         writes;
    int         syncs;
    int         err_at_start;
    logic       idle_dropped;
    string      verdict;

    task automatic mismatch(input string name, input int exp, input int act);
        $display("MISMATCH time=%0t %s expected=%0h actual=%0h", $time, name, exp, act);
        errors = errors + 1;
    endtask

    task automatic failure(input string what);
        $display("ERROR time=%0t %s", $time, what);
        errors = errors + 1;
    endtask

    initial
    begin
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        done_cnt     = 0;
        writes       = 0;
        syncs        = 0;
        err_at_start = 0;
        idle_dropped = 1'b0;
        txsync_prev  = '0;
        for (int i = 0; i < LANES; i++)
        begin
            wr_idx[i]      = 0;
            outstanding[i] = 1'b0;
        end
    end

    always @(posedge RATE_CLK)
    begin
        if (RATE_RST_N)
        begin
            for (int i = 0; i < LANES; i++)
            begin
                if (drp_en[i])
                begin
                    if (outstanding[i])
                        failure($sformatf(
                            "lane %0d issued a DRP write before the last one was answered", i));
                    if (!drp_we[i])
                        mismatch($sformatf("drp_we[%0d]", i), 1, int'(drp_we[i]));
                    if (drp_addr[i] != DRP_ADDR_WIDTH_CFG)
                        mismatch($sformatf("drp_addr[%0d]", i), int'(DRP_ADDR_WIDTH_CFG),
                                 int'(drp_addr[i]));
                    if (wr_idx[i] >= 2)
                        failure($sformatf(
                            "lane %0d made more than two DRP writes in one change", i));
                    else if (drp_di[i] != ((wr_idx[i] == 0) ? DRP_VAL_X16 : DRP_VAL_X20))
                        mismatch($sformatf("drp_di[%0d]", i),
                                 int'((wr_idx[i] == 0) ? DRP_VAL_X16 : DRP_VAL_X20),
                                 int'(drp_di[i]));
                    outstanding[i] = 1'b1;
                    wr_idx[i]      = wr_idx[i] + 1;
                    writes         = writes + 1;
                end
                if (drp_rdy[i])
                    outstanding[i] = 1'b0;
                if (txsync_start[i] && !txsync_prev[i])
                    syncs = syncs + 1;
            end
            txsync_prev = txsync_start;

            if (test_kind == 2'd2 && !rate_idle)
                idle_dropped = 1'b1;

            if (rate_done)
            begin
                done_cnt = done_cnt + 1;
                for (int i = 0; i < LANES; i++)
                begin
                    if (rate_out[i] != ((req == 2'd1) ? 3'd1 : 3'd0))
                        mismatch($sformatf("rate_out[%0d]", i), (req == 2'd1) ? 1 : 0,
                                 int'(rate_out[i]));
                    if (pclk_sel[i] != (req == 2'd1))
                        mismatch($sformatf("pclk_sel[%0d]", i), (req == 2'd1) ? 1 : 0,
                                 int'(pclk_sel[i]));
                    if (wr_idx[i] != 2)
                        failure($sformatf("lane %0d finished with %0d DRP writes", i, wr_idx[i]));
                    if (!events_done[i] || !sync_done[i])
                        failure($sformatf("rate_done came before the GT of lane %0d finished", i));
                end
            end

            if (test_end)
            begin
                case (test_kind)
                    2'd0:
                    begin
                        if (!rate_idle)
                            mismatch("rate_idle", 1, 0);
                        if (rate_done)
                            mismatch("rate_done", 0, 1);
                        if (drp_en != '0)
                            mismatch("drp_en", 0, int'(drp_en));
                        if (txsync_start != '0)
                            mismatch("txsync_start", 0, int'(txsync_start));
                        if (pclk_sel != '0)
                            mismatch("pclk_sel", 0, int'(pclk_sel));
                        for (int i = 0; i < LANES; i++)
                            if (rate_out[i] != 3'd0)
                                mismatch($sformatf("rate_out[%0d]", i), 0, int'(rate_out[i]));
                    end
                    2'd1:
                    begin
                        if (done_cnt != 1)
                            failure($sformatf("rate change gave %0d rate_done pulses", done_cnt));
                        if (writes != 2 * LANES)
                            failure($sformatf("rate change gave %0d DRP writes", writes));
                    end
                    default:
                    begin
                        if (done_cnt != 0 || writes != 0 || syncs != 0)
                            failure("same-value write started a rate change");
                        if (idle_dropped)
                            failure("rate_idle fell after a same-value write");
                    end
                endcase
                tests_run = tests_run + 1;
                if (errors != err_at_start)
                begin
                    tests_failed = tests_failed + 1;
                    verdict      = "failed";
                end
                else
                begin
                    verdict = "ok";
                end
                $display("test %0d kind %0d rate %0d: %s", test_num, test_kind, req, verdict);
                err_at_start = errors;
                done_cnt     = 0;
                writes       = 0;
                syncs        = 0;
                idle_dropped = 1'b0;
                for (int i = 0; i < LANES; i++)
                    wr_idx[i] = 0;
            end
        end
    end

endmodule

// File: sim/tb_clock_gen.sv
module tb_clock_gen (
    output logic RATE_CLK,
    output logic RATE_RST_N
);

    initial
    begin
        RATE_CLK = 1'b0;
        forever #4 RATE_CLK = ~RATE_CLK;
    end

    initial
    begin
        RATE_RST_N = 1'b0;
        repeat (5) @(negedge RATE_CLK);
        RATE_RST_N = 1'b1; // Released on a falling edge, away from the sampling edge.
    end

endmodule

// File: sim/tb_pipe_rate.sv
module tb_pipe_rate;
    import pipe_rate_pkg::*;

    localparam int LANES          = 4;
    localparam int TIMEOUT_CYCLES = 42 * 400;

    logic                  RATE_CLK;
    logic                  RATE_RST_N;
    pcie_rate_t            rate_in;
    pcie_rate_t            req;
    logic      [1:0]       test_kind;
    logic                  test_end;
    int                    test_num;
    int                    cycles;
    logic      [LANES-1:0] rxpmaresetdone;
    logic      [LANES-1:0] txratedone;
    logic      [LANES-1:0] rxratedone;
    logic      [LANES-1:0] phystatus;
    logic      [LANES-1:0] txsync_done;
    logic      [LANES-1:0] drp_rdy;
    logic      [LANES-1:0] pclk_sel;
    gt_rate_t  [LANES-1:0] rate_out;
    logic      [LANES-1:0] txsync_start;
    logic      [LANES-1:0] drp_en;
    logic      [LANES-1:0] drp_we;
    drp_addr_t [LANES-1:0] drp_addr;
    drp_data_t [LANES-1:0] drp_di;
    logic                  rate_done;
    logic                  rate_idle;
    logic      [LANES-1:0] events_done;
    logic      [LANES-1:0] sync_done;
    int                    errors;
    int                    tests_run;
    int                    tests_failed;

    tb_clock_gen u_clk (
        .RATE_CLK   (RATE_CLK),
        .RATE_RST_N (RATE_RST_N)
    );

    pipe_rate_top #(
        .LANES       (LANES),
        .SIM_SPEEDUP (1'b0)
    ) uut (
        .RATE_CLK       (RATE_CLK),
        .RATE_RST_N     (RATE_RST_N),
        .rate_in        (rate_in),
        .rxpmaresetdone (rxpmaresetdone),
        .txratedone     (txratedone),
        .rxratedone     (rxratedone),
        .phystatus      (phystatus),
        .txsync_done    (txsync_done),
        .drp_rdy        (drp_rdy),
        .pclk_sel       (pclk_sel),
        .rate_out       (rate_out),
        .txsync_start   (txsync_start),
        .drp_en         (drp_en),
        .drp_we         (drp_we),
        .drp_addr       (drp_addr),
        .drp_di         (drp_di),
        .rate_done      (rate_done),
        .rate_idle      (rate_idle)
    );

    for (genvar i = 0; i < LANES; i++)
    begin : g_gt
        gt_lane_model u_gt (
            .RATE_CLK       (RATE_CLK),
            .drp_en         (drp_en[i]),
            .drp_we         (drp_we[i]),
            .drp_addr       (drp_addr[i]),
            .drp_di         (drp_di[i]),
            .txsync_start   (txsync_start[i]),
            .drp_rdy        (drp_rdy[i]),
            .rxpmaresetdone (rxpmaresetdone[i]),
            .txratedone     (txratedone[i]),
            .rxratedone     (rxratedone[i]),
            .phystatus      (phystatus[i]),
            .txsync_done    (txsync_done[i]),
            .events_done    (events_done[i]),
            .sync_done      (sync_done[i])
        );
    end

    tb_checker #(
        .LANES (LANES)
    ) u_chk (
        .RATE_CLK     (RATE_CLK),
        .RATE_RST_N   (RATE_RST_N),
        .req          (req),
        .test_kind    (test_kind),
        .test_end     (test_end),
        .test_num     (test_num),
        .pclk_sel     (pclk_sel),
        .rate_out     (rate_out),
        .txsync_start (txsync_start),
        .drp_en       (drp_en),
        .drp_we       (drp_we),
        .drp_addr     (drp_addr),
        .drp_di       (drp_di),
        .drp_rdy      (drp_rdy),
        .rate_done    (rate_done),
        .rate_idle    (rate_idle),
        .events_done  (events_done),
        .sync_done    (sync_done),
        .errors       (errors),
        .tests_run    (tests_run),
        .tests_failed (tests_failed)
    );

    task automatic close_test();
        @(negedge RATE_CLK);
        test_end = 1'b1;
        @(negedge RATE_CLK);
        test_end = 1'b0;
        test_num = test_num + 1;
    endtask

    task automatic change_rate();
        pcie_rate_t next;
        next = pcie_rate_t'($urandom_range(3, 0));
        while (next == rate_in)
            next = pcie_rate_t'($urandom_range(3, 0));
        @(negedge RATE_CLK);
        test_kind = 2'd1;
        rate_in   = next;
        req       = next;
        do
            @(negedge RATE_CLK);
        while (!rate_done);
        repeat ($urandom_range(10, 0)) @(negedge RATE_CLK);
        close_test();
    endtask

    task automatic rewrite_rate();
        @(negedge RATE_CLK);
        test_kind = 2'd2;
        rate_in   = req; // Same value again.
        repeat (400) @(negedge RATE_CLK);
        close_test();
    endtask

    initial
    begin
        void'($urandom(32'h6205b334));
        rate_in   = 2'd0;
        req       = 2'd0;
        test_kind = 2'd0;
        test_end  = 1'b0;
        test_num  = 0;
        @(posedge RATE_RST_N);
        repeat (2) @(negedge RATE_CLK);
        close_test();
        for (int n = 0; n < 40; n++)
        begin
            change_rate();
            if (n == 12 || n == 31)
                rewrite_rate();
        end
        @(negedge RATE_CLK);
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    initial
    begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES)
        begin
            @(posedge RATE_CLK);
            cycles = cycles + 1;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: source/pipe_drp_writer.sv
module pipe_drp_writer
    import pipe_rate_pkg::*;
(
    input  logic      RATE_CLK,
    input  logic      RATE_RST_N,
    input  logic      drp_start,
    input  logic      drp_x16,
    input  logic      drp_rdy,
    output logic      drp_done,
    output logic      drp_en,
    output logic      drp_we,
    output drp_addr_t drp_addr,
    output drp_data_t drp_di
);

    typedef enum logic [1:0] {
        WR_READY = 2'd0,
        WR_ISSUE = 2'd1,
        WR_WAIT  = 2'd2
    } wr_state_e;

    wr_state_e state;
    logic      wr_pending;

    always_ff @(posedge RATE_CLK)
    begin
        if (!RATE_RST_N)
            state <= WR_READY;
        else
        begin
            unique case (state)
                WR_READY:
                    if (drp_start)
                        state <= WR_ISSUE;
                WR_ISSUE:
                    state <= WR_WAIT;
                WR_WAIT:
                    if (drp_rdy)
                        state <= WR_READY; // Port has accepted the write.
                default:
                    state <= WR_READY;
            endcase
        end
    end

    // Address and data stay stable until the port answers.
    always_ff @(posedge RATE_CLK)
    begin
        if ((state == WR_READY) && drp_start)
        begin
            drp_addr <= DRP_ADDR_WIDTH_CFG;
            drp_di   <= drp_x16 ? DRP_VAL_X16 : DRP_VAL_X20;
        end
    end

    assign drp_en   = (state == WR_ISSUE);
    assign drp_we   = (state == WR_ISSUE);
    assign drp_done = (state == WR_READY);

    always_ff @(posedge RATE_CLK)
    begin
        if (!RATE_RST_N)
            wr_pending <= 1'b0;
        else if (drp_rdy)
            wr_pending <= 1'b0;
        else if (drp_en)
            wr_pending <= 1'b1;
    end

    a_no_overlap: assert property (@(posedge RATE_CLK) disable iff (!RATE_RST_N)
        !(drp_en && wr_pending));

endmodule

// File: source/pipe_lane_rate.sv
module pipe_lane_rate
    import pipe_rate_pkg::*;
#(
    parameter bit         SIM_SPEEDUP     = 1'b0,
    parameter logic [3:0] TXDATA_WAIT_MAX = 4'd15
) (
    input  logic       RATE_CLK,
    input  logic       RATE_RST_N,
    input  pcie_rate_t rate_in,
    input  logic       rxpmaresetdone,
    input  logic       txratedone,
    input  logic       rxratedone,
    input  logic       phystatus,
    input  logic       txsync_done,
    input  logic       drp_done,
    output logic       pclk_sel,
    output logic       drp_start,
    output logic       drp_x16,
    output gt_rate_t   rate_out,
    output logic       txsync_start,
    output logic       lane_done,
    output logic       lane_idle
);

    pcie_rate_t rate_q;
    pcie_rate_t rate_q1;
    logic [4:0] status_q;
    logic       pmarst_done_q;
    logic       txratedone_q;
    logic       rxratedone_q;
    logic       phystatus_q;
    logic       txsync_done_q;

    rate_fsm_e  state;
    rate_fsm_e  state_nxt;
    logic [3:0] wait_cnt;
    logic       seen_txrate;
    logic       seen_rxrate;
    logic       seen_phystatus;
    logic       collect_win;
    gt_rate_t   rate_gt;

    pipe_rate_sync #(
        .data_t (pcie_rate_t)
    ) u_rate_sync (
        .RATE_CLK   (RATE_CLK),
        .RATE_RST_N (RATE_RST_N),
        .d          (rate_in),
        .q          (rate_q),
        .q_prev     (rate_q1)
    );

    pipe_rate_sync #(
        .data_t (logic [4:0])
    ) u_status_sync (
        .RATE_CLK   (RATE_CLK),
        .RATE_RST_N (RATE_RST_N),
        .d          ({rxpmaresetdone, txratedone, rxratedone, phystatus, txsync_done}),
        .q          (status_q),
        .q_prev     ()
    );

    assign {pmarst_done_q, txratedone_q, rxratedone_q, phystatus_q, txsync_done_q} = status_q;

    assign rate_gt = (rate_q == PCIE_RATE_GEN2) ? GT_RATE_GEN2 : GT_RATE_GEN1;

    // Status events may come in any order once the rate has been applied.
    assign collect_win = (state == FSM_RXPMARESETDONE) || (state == FSM_DRP_X20_START) ||
                         (state == FSM_DRP_X20_DONE) || (state == FSM_RATE_DONE);

    always_ff @(posedge RATE_CLK)
    begin
        if (!RATE_RST_N)
            wait_cnt <= 4'd0;
        else if (state != FSM_TXDATA_WAIT)
            wait_cnt <= 4'd0;
        else if (wait_cnt != TXDATA_WAIT_MAX)
            wait_cnt <= wait_cnt + 4'd1;
    end

    always_ff @(posedge RATE_CLK)
    begin
        if (!RATE_RST_N || !collect_win)
        begin
            seen_txrate    <= 1'b0;
            seen_rxrate    <= 1'b0;
            seen_phystatus <= 1'b0;
        end
        else
        begin
            seen_txrate    <= seen_txrate | txratedone_q;
            seen_rxrate    <= seen_rxrate | rxratedone_q;
            seen_phystatus <= seen_phystatus | phystatus_q;
        end
    end

    always_comb
    begin
        state_nxt = state;
        unique case (state)
            FSM_IDLE:
                if (rate_q != rate_q1)
                    state_nxt = FSM_TXDATA_WAIT;
            FSM_TXDATA_WAIT:
                if (wait_cnt == TXDATA_WAIT_MAX)
                    state_nxt = FSM_PCLK_SEL;
            FSM_PCLK_SEL:
                state_nxt = SIM_SPEEDUP ? FSM_RATE_SEL : FSM_DRP_X16_START;
            FSM_DRP_X16_START:
                if (!drp_done)
                    state_nxt = FSM_DRP_X16_DONE; // Writer has taken the request.
            FSM_DRP_X16_DONE:
                if (drp_done)
                    state_nxt = FSM_RATE_SEL;
            FSM_RATE_SEL:
                state_nxt = SIM_SPEEDUP ? FSM_RATE_DONE : FSM_RXPMARESETDONE;
            FSM_RXPMARESETDONE:
                if (!pmarst_done_q)
                    state_nxt = FSM_DRP_X20_START;
            FSM_DRP_X20_START:
                if (!drp_done)
                    state_nxt = FSM_DRP_X20_DONE;
            FSM_DRP_X20_DONE:
                if (drp_done)
                    state_nxt = FSM_RATE_DONE;
            FSM_RATE_DONE:
                if (seen_txrate && seen_rxrate && seen_phystatus)
                    state_nxt = FSM_TXSYNC_START;
            FSM_TXSYNC_START:
                if (!txsync_done_q)
                    state_nxt = FSM_TXSYNC_DONE;
            FSM_TXSYNC_DONE:
                if (txsync_done_q)
                    state_nxt = FSM_DONE;
            FSM_DONE:
                state_nxt = FSM_IDLE;
            default:
                state_nxt = FSM_IDLE;
        endcase
    end

    always_ff @(posedge RATE_CLK)
    begin
        if (!RATE_RST_N)
        begin
            state    <= FSM_IDLE;
            pclk_sel <= 1'b0;
            rate_out <= GT_RATE_GEN1;
        end
        else
        begin
            state <= state_nxt;
            if (state == FSM_PCLK_SEL)
                pclk_sel <= (rate_q == PCIE_RATE_GEN2);
            if (state == FSM_RATE_SEL)
                rate_out <= rate_gt; // New rate goes out after the width drop.
        end
    end

    assign drp_start    = (state == FSM_DRP_X16_START) || (state == FSM_DRP_X20_START);
    assign drp_x16      = (state == FSM_DRP_X16_START) || (state == FSM_DRP_X16_DONE);
    assign txsync_start = (state == FSM_TXSYNC_START);
    assign lane_done    = (state == FSM_DONE);
    assign lane_idle    = (state == FSM_IDLE);

    a_state_legal: assert property (@(posedge RATE_CLK) disable iff (!RATE_RST_N)
        !$isunknown(state) && (state <= FSM_DONE));

    a_drp_txsync_excl: assert property (@(posedge RATE_CLK) disable iff (!RATE_RST_N)
        !(drp_start && txsync_start));

endmodule

// File: source/pipe_rate_align.sv
module pipe_rate_align #(
    parameter int unsigned LANES = 4
) (
    input  logic             RATE_CLK,
    input  logic             RATE_RST_N,
    input  logic [LANES-1:0] lane_done,
    input  logic [LANES-1:0] lane_idle,
    output logic             rate_done,
    output logic             rate_idle
);

    logic [LANES-1:0] done_seen;
    logic [LANES-1:0] done_all;

    // Include this cycle's pulses so the last lane does not cost an extra cycle.
    assign done_all = done_seen | lane_done;

    always_ff @(posedge RATE_CLK)
    begin
        if (!RATE_RST_N)
        begin
            done_seen <= '0;
            rate_done <= 1'b0;
        end
        else if (&done_all)
        begin
            done_seen <= '0;
            rate_done <= 1'b1;
        end
        else
        begin
            done_seen <= done_all;
            rate_done <= 1'b0;
        end
    end

    assign rate_idle = &lane_idle;

    a_done_single: assert property (@(posedge RATE_CLK) disable iff (!RATE_RST_N)
        rate_done |=> !rate_done);

endmodule

// File: source/pipe_rate_pkg.sv
package pipe_rate_pkg;

    // Link-side rate request. Codes other than Gen2 are handled as Gen1.
    typedef logic [1:0] pcie_rate_t;
    typedef logic [2:0] gt_rate_t;
    typedef logic [8:0] drp_addr_t;
    typedef logic [15:0] drp_data_t;

    localparam pcie_rate_t PCIE_RATE_GEN1 = 2'd0;
    localparam pcie_rate_t PCIE_RATE_GEN2 = 2'd1;

    localparam gt_rate_t GT_RATE_GEN1 = 3'd0;
    localparam gt_rate_t GT_RATE_GEN2 = 3'd1;

    localparam drp_addr_t DRP_ADDR_WIDTH_CFG = 9'h011; // TX/RX data width register.
    localparam drp_data_t DRP_VAL_X16 = 16'h0003;
    localparam drp_data_t DRP_VAL_X20 = 16'h0004;

    typedef enum logic [3:0] {
        FSM_IDLE           = 4'd0,
        FSM_TXDATA_WAIT    = 4'd1,
        FSM_PCLK_SEL       = 4'd2,
        FSM_DRP_X16_START  = 4'd3,
        FSM_DRP_X16_DONE   = 4'd4,
        FSM_RATE_SEL       = 4'd5,
        FSM_RXPMARESETDONE = 4'd6,
        FSM_DRP_X20_START  = 4'd7,
        FSM_DRP_X20_DONE   = 4'd8,
        FSM_RATE_DONE      = 4'd9,
        FSM_TXSYNC_START   = 4'd10,
        FSM_TXSYNC_DONE    = 4'd11,
        FSM_DONE           = 4'd12
    } rate_fsm_e;

endpackage

// File: source/pipe_rate_sync.sv
module pipe_rate_sync #(
    parameter type data_t = logic
) (
    input  logic  RATE_CLK,
    input  logic  RATE_RST_N,
    input  data_t d,
    output data_t q,
    output data_t q_prev
);

    data_t stage1;
    data_t stage2;

    always_ff @(posedge RATE_CLK)
    begin
        if (!RATE_RST_N)
        begin
            stage1 <= '0;
            stage2 <= '0;
        end
        else
        begin
            stage1 <= d;
            stage2 <= stage1; // Second flop settles any metastability.
        end
    end

    assign q      = stage2;
    assign q_prev = stage1; // Lets the caller compare the two stages.

endmodule

// File: source/pipe_rate_top.sv
module pipe_rate_top
    import pipe_rate_pkg::*;
#(
    parameter int unsigned LANES           = 4,
    parameter bit          SIM_SPEEDUP     = 1'b0,
    parameter logic [3:0]  TXDATA_WAIT_MAX = 4'd15
) (
    input  logic                        RATE_CLK,
    input  logic                        RATE_RST_N,
    input  pcie_rate_t                  rate_in,
    input  logic      [LANES-1:0]       rxpmaresetdone,
    input  logic      [LANES-1:0]       txratedone,
    input  logic      [LANES-1:0]       rxratedone,
    input  logic      [LANES-1:0]       phystatus,
    input  logic      [LANES-1:0]       txsync_done,
    input  logic      [LANES-1:0]       drp_rdy,
    output logic      [LANES-1:0]       pclk_sel,
    output gt_rate_t  [LANES-1:0]       rate_out,
    output logic      [LANES-1:0]       txsync_start,
    output logic      [LANES-1:0]       drp_en,
    output logic      [LANES-1:0]       drp_we,
    output drp_addr_t [LANES-1:0]       drp_addr,
    output drp_data_t [LANES-1:0]       drp_di,
    output logic                        rate_done,
    output logic                        rate_idle
);

    logic [LANES-1:0] drp_start;
    logic [LANES-1:0] drp_x16;
    logic [LANES-1:0] drp_done;
    logic [LANES-1:0] lane_done;
    logic [LANES-1:0] lane_idle;

    for (genvar i = 0; i < LANES; i++)
    begin : g_lane
        pipe_lane_rate #(
            .SIM_SPEEDUP     (SIM_SPEEDUP),
            .TXDATA_WAIT_MAX (TXDATA_WAIT_MAX)
        ) u_lane (
            .RATE_CLK       (RATE_CLK),
            .RATE_RST_N     (RATE_RST_N),
            .rate_in        (rate_in),
            .rxpmaresetdone (rxpmaresetdone[i]),
            .txratedone     (txratedone[i]),
            .rxratedone     (rxratedone[i]),
            .phystatus      (phystatus[i]),
            .txsync_done    (txsync_done[i]),
            .drp_done       (drp_done[i]),
            .pclk_sel       (pclk_sel[i]),
            .drp_start      (drp_start[i]),
            .drp_x16        (drp_x16[i]),
            .rate_out       (rate_out[i]),
            .txsync_start   (txsync_start[i]),
            .lane_done      (lane_done[i]),
            .lane_idle      (lane_idle[i])
        );

        pipe_drp_writer u_drp (
            .RATE_CLK   (RATE_CLK),
            .RATE_RST_N (RATE_RST_N),
            .drp_start  (drp_start[i]),
            .drp_x16    (drp_x16[i]),
            .drp_rdy    (drp_rdy[i]),
            .drp_done   (drp_done[i]),
            .drp_en     (drp_en[i]),
            .drp_we     (drp_we[i]),
            .drp_addr   (drp_addr[i]),
            .drp_di     (drp_di[i])
        );
    end

    pipe_rate_align #(
        .LANES (LANES)
    ) u_align (
        .RATE_CLK   (RATE_CLK),
        .RATE_RST_N (RATE_RST_N),
        .lane_done  (lane_done),
        .lane_idle  (lane_idle),
        .rate_done  (rate_done),
        .rate_idle  (rate_idle)
    );

endmodule

// File: verilog.f
source/pipe_rate_pkg.sv
source/pipe_rate_sync.sv
source/pipe_lane_rate.sv
source/pipe_drp_writer.sv
source/pipe_rate_align.sv
source/pipe_rate_top.sv
sim/tb_clock_gen.sv
sim/gt_lane_model.sv
sim/tb_checker.sv
sim/tb_pipe_rate.sv
